/* Makefile */
TOP := lane_mon_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
		--top-module $(TOP) -f all.f -o $(TOP)

# The simulator status is not trusted alone, the log decides
run: compile
	./obj_dir/$(TOP) > run.log 2>&1; cat run.log
	grep -q "test passed" run.log

clean:
	rm -rf obj_dir run.log

/* all.f */
hdl/lane_mon_pkg.sv
hdl/wb_reg_decode.sv
hdl/lane_pattern_check.sv
hdl/link_status_result.sv
hdl/lane_mon_top.sv
tests/tb_clock_gen.sv
tests/lane_mon_props.sv
tests/lane_mon_tb.sv

/* hdl/lane_mon_pkg.sv */
package lane_mon_pkg;

    // Lane and symbol geometry
    localparam int NUM_LANES  = 4;
    localparam int SYM_W      = 2;
    localparam int WINDOW_LEN = 64;
    localparam int WIN_CNT_W  = $clog2(WINDOW_LEN);
    localparam int ERR_LIMIT  = 8;

    // Wishbone bus widths
    localparam int WB_ADR_W = 4;
    localparam int WB_DAT_W = 32;

    typedef logic [SYM_W-1:0]     sym_t;
    typedef logic [15:0]          ber_t;
    typedef logic [7:0]           eye_t;
    typedef logic [NUM_LANES-1:0] lane_mask_t;
    typedef logic [WB_ADR_W-1:0]  wb_adr_t;
    typedef logic [WB_DAT_W-1:0]  wb_dat_t;
    typedef logic [15:0]          iter_t;

    // Eye height with a clean window
    localparam eye_t EYE_MAX = 8'hFF;

    // Word-granular register addresses
    localparam wb_adr_t ADR_CTRL      = 4'd0;
    localparam wb_adr_t ADR_STATUS    = 4'd1;
    localparam wb_adr_t ADR_ITER      = 4'd2;
    localparam wb_adr_t ADR_LANE_BASE = 4'd4;

    // Field positions inside the registers
    localparam int CTRL_TRAIN_BIT = 0;
    localparam int CTRL_EN_LSB    = 4;
    localparam int STAT_TRAIN_BIT = 30;
    localparam int STAT_ACT_LSB   = 8;
    localparam int STAT_ERR_LSB   = 0;
    localparam int STAT_CNT_W     = 8;
    localparam int LANE_BER_LSB   = 0;
    localparam int LANE_EYE_LSB   = 16;
    localparam int LANE_FLAG_BIT  = 24;

    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        wb_dat_t dat;
    } wb_req_t;

    typedef struct packed {
        logic    ack;
        wb_dat_t dat;
    } wb_rsp_t;

    typedef struct packed {
        lane_mask_t lane_enable;
        logic       training_mode;
    } mon_ctrl_t;

    // Ordered to mirror the LANE register layout
    typedef struct packed {
        logic error_flag;
        eye_t eye_height;
        ber_t ber;
    } lane_report_t;

endpackage

/* hdl/lane_mon_top.sv */
`timescale 1ns/100ps

module lane_mon_top
    import lane_mon_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,

    // Wishbone classic slave port
    input  wb_req_t                wb_req,
    output wb_rsp_t                wb_rsp,

    // Received lane symbols
    input  sym_t [NUM_LANES-1:0]   rx_symbols,
    input  lane_mask_t             rx_valid,

    output lane_mask_t             lane_error_flag
);

    mon_ctrl_t    ctrl;
    wb_adr_t      rd_sel;
    wb_dat_t      rd_data;
    lane_report_t lane_reports [NUM_LANES];

    wb_reg_decode u_decode (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .rd_data (rd_data),
        .ctrl    (ctrl),
        .rd_sel  (rd_sel)
    );

    // One checker per lane with a shared control register
    for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
        lane_pattern_check u_lane (
            .clk      (clk),
            .rst_n    (rst_n),
            .sym      (rx_symbols[i]),
            .valid    (rx_valid[i]),
            .enable   (ctrl.lane_enable[i]),
            .training (ctrl.training_mode),
            .report   (lane_reports[i])
        );
    end

    link_status_result u_result (
        .clk             (clk),
        .rst_n           (rst_n),
        .ctrl            (ctrl),
        .reports         (lane_reports),
        .rd_sel          (rd_sel),
        .rd_data         (rd_data),
        .lane_error_flag (lane_error_flag)
    );

endmodule

/* hdl/lane_pattern_check.sv */
`timescale 1ns/100ps

module lane_pattern_check
    import lane_mon_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    // Received symbol stream for this lane
    input  sym_t         sym,
    input  logic         valid,

    // Controls from the CTRL register
    input  logic         enable,
    input  logic         training,

    // Window result for readback and flagging
    output lane_report_t report
);

    logic [WIN_CNT_W-1:0] sym_cnt;
    ber_t                 err_cnt;
    ber_t                 err_next;
    ber_t                 ber_q;
    sym_t                 expected;
    logic                 accept;
    logic                 mismatch;
    logic                 window_end;

    // Disabled lane ignores its input and holds every count
    assign accept = valid && enable;

    // Training pattern walks 0,1,2,3 with the symbol count
    assign expected = sym_cnt[SYM_W-1:0];

    // Only scored while training is on
    assign mismatch = training && (sym != expected);

    assign err_next = err_cnt + ber_t'(mismatch);

    // Last symbol of a window
    assign window_end = (sym_cnt == WIN_CNT_W'(WINDOW_LEN - 1));

    // Symbol counter
    // Wraps at the window length, so it doubles as the window position
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sym_cnt <= '0;
        end else if (accept) begin
            sym_cnt <= sym_cnt + 1'b1;
        end
    end

    // Window error count and BER estimate
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_cnt <= '0;
            ber_q   <= '0;
        end else if (accept) begin
            if (window_end) begin
                // Includes the error of the closing symbol
                ber_q   <= err_next;
                err_cnt <= '0;
            end else begin
                err_cnt <= err_next;
            end
        end
    end

    // Eye height and flag follow the latest estimate
    always_comb begin
        report.ber        = ber_q;
        report.eye_height = EYE_MAX - ber_q[$bits(eye_t)-1:0];
        report.error_flag = (ber_q > ber_t'(ERR_LIMIT));
    end

endmodule

/* hdl/link_status_result.sv */
`timescale 1ns/100ps

module link_status_result
    import lane_mon_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    // Control and per-lane results
    input  mon_ctrl_t    ctrl,
    input  lane_report_t reports [NUM_LANES],

    // Readback path
    input  wb_adr_t      rd_sel,
    output wb_dat_t      rd_data,

    output lane_mask_t   lane_error_flag
);

    logic                  train_active_q;
    iter_t                 iter_q;
    logic [STAT_CNT_W-1:0] active_cnt;
    logic [STAT_CNT_W-1:0] error_cnt;
    lane_mask_t            flags;
    wb_dat_t               status_word;

    // Training active lags training_mode by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            train_active_q <= 1'b0;
        end else begin
            train_active_q <= ctrl.training_mode;
        end
    end

    // One iteration per cycle of active training
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iter_q <= '0;
        end else if (train_active_q) begin
            iter_q <= iter_q + 1'b1;
        end
    end

    // Lane totals
    always_comb begin
        active_cnt = '0;
        error_cnt  = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            flags[i]   = reports[i].error_flag;
            active_cnt = active_cnt + STAT_CNT_W'(ctrl.lane_enable[i]);
            error_cnt  = error_cnt + STAT_CNT_W'(reports[i].error_flag);
        end
    end

    assign lane_error_flag = flags;

    // Status bits outside the three fields read as zero
    always_comb begin
        status_word                               = '0;
        status_word[STAT_TRAIN_BIT]               = train_active_q;
        status_word[STAT_ACT_LSB +: STAT_CNT_W]   = active_cnt;
        status_word[STAT_ERR_LSB +: STAT_CNT_W]   = error_cnt;
    end

    // Read multiplexer with zero for unmapped addresses
    always_comb begin
        rd_data = '0;
        case (rd_sel)
            ADR_CTRL: begin
                rd_data[CTRL_TRAIN_BIT]          = ctrl.training_mode;
                rd_data[CTRL_EN_LSB +: NUM_LANES] = ctrl.lane_enable;
            end
            ADR_STATUS: rd_data = status_word;
            ADR_ITER:   rd_data = wb_dat_t'(iter_q);
            default: begin
                for (int i = 0; i < NUM_LANES; i++) begin
                    if (rd_sel == ADR_LANE_BASE + wb_adr_t'(i)) begin
                        rd_data[LANE_BER_LSB +: $bits(ber_t)] = reports[i].ber;
                        rd_data[LANE_EYE_LSB +: $bits(eye_t)] = reports[i].eye_height;
                        rd_data[LANE_FLAG_BIT]                = reports[i].error_flag;
                    end
                end
            end
        endcase
    end

endmodule

/* hdl/wb_reg_decode.sv */
`timescale 1ns/100ps

module wb_reg_decode
    import lane_mon_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // Wishbone slave side
    input  wb_req_t   wb_req,
    output wb_rsp_t   wb_rsp,

    // Read data from the result block
    input  wb_dat_t   rd_data,

    // Control register and read select
    output mon_ctrl_t ctrl,
    output wb_adr_t   rd_sel
);

    logic      ack_q;
    logic      access;
    logic      wr_ctrl;
    mon_ctrl_t ctrl_q;
    wb_adr_t   rd_sel_q;

    // New cycle seen while no acknowledge is pending
    assign access  = wb_req.cyc && wb_req.stb && !ack_q;
    assign wr_ctrl = access && wb_req.we && (wb_req.adr == ADR_CTRL);

    // Single-cycle acknowledge that never stalls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // Latch the address so read data lines up with ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_sel_q <= ADR_CTRL;
        end else if (access) begin
            rd_sel_q <= wb_req.adr;
        end
    end

    // Control register
    // Writes elsewhere are acknowledged and dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q.training_mode <= 1'b0;
            ctrl_q.lane_enable   <= '0;
        end else if (wr_ctrl) begin
            ctrl_q.training_mode <= wb_req.dat[CTRL_TRAIN_BIT];
            ctrl_q.lane_enable   <= wb_req.dat[CTRL_EN_LSB +: NUM_LANES];
        end
    end

    assign ctrl   = ctrl_q;
    assign rd_sel = rd_sel_q;

    // Data only driven during the ack cycle
    always_comb begin
        wb_rsp.ack = ack_q;
        wb_rsp.dat = ack_q ? rd_data : '0;
    end

endmodule

/* tests/lane_mon_props.sv */
`timescale 1ns/100ps

module lane_mon_props
    import lane_mon_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input wb_req_t    wb_req,
    input wb_rsp_t    wb_rsp,
    input lane_mask_t lane_error_flag
);

    // Acknowledge lasts exactly one cycle
    ack_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) wb_rsp.ack |=> !wb_rsp.ack
    ) else $error("ack stayed high for two cycles");

    // Acknowledge only answers a request
    ack_after_request: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(wb_rsp.ack) |-> $past(wb_req.cyc && wb_req.stb)
    ) else $error("ack rose without cyc and stb");

    // No lane flagged while reset is held
    flags_clear_in_reset: assert property (
        @(posedge clk) !rst_n |-> (lane_error_flag == '0)
    ) else $error("lane_error_flag set during reset");

endmodule

bind lane_mon_top lane_mon_props u_props (
    .clk             (clk),
    .rst_n           (rst_n),
    .wb_req          (wb_req),
    .wb_rsp          (wb_rsp),
    .lane_error_flag (lane_error_flag)
);

/* tests/lane_mon_tb.sv */
`timescale 1ns/100ps

module lane_mon_tb
    import lane_mon_pkg::*;
;

    typedef enum logic [2:0] {
        ST_WRITE, ST_READ, ST_BURST, ST_IDLE, ST_FLAGS, ST_ITER_SNAP, ST_ITER_UP, ST_ITER_HOLD
    } step_kind_t;

    // dat is write data, expected read data or expected flags
    typedef struct packed {
        step_kind_t  kind;
        wb_adr_t     adr;
        wb_dat_t     dat;
        logic [15:0] count;
        lane_mask_t  valid_mask;
        lane_mask_t  err_mask;
    } step_t;

    logic                 clk;
    logic                 rst_n;
    wb_req_t              wb_req;
    wb_rsp_t              wb_rsp;
    sym_t [NUM_LANES-1:0] rx_symbols;
    lane_mask_t           rx_valid;
    lane_mask_t           lane_error_flag;

    step_t      steps [64];
    int         num_steps;
    logic       table_ready;
    int         lane_cnt [NUM_LANES];
    lane_mask_t lane_en;
    wb_dat_t    iter_snap;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    lane_mon_top u_lane_mon_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .wb_req          (wb_req),
        .wb_rsp          (wb_rsp),
        .rx_symbols      (rx_symbols),
        .rx_valid        (rx_valid),
        .lane_error_flag (lane_error_flag)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_value(input string name, input wb_dat_t actual, input wb_dat_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("Error at %0t ns: %s is 0x%08h, expected 0x%08h",
                                $time, name, actual, expected));
        end
    endtask

    function automatic void add_step(input step_kind_t kind, input wb_adr_t adr,
                                     input wb_dat_t dat, input int count,
                                     input lane_mask_t valid_mask, input lane_mask_t err_mask);
        steps[num_steps] = '{kind, adr, dat, 16'(count), valid_mask, err_mask};
        num_steps++;
    endfunction

    task automatic build_table();
        // Reset values with eye height at 255
        add_step(ST_READ,  ADR_CTRL,            32'h0000_0000, 0, 4'h0, 4'h0);
        add_step(ST_READ,  ADR_STATUS,          32'h0000_0000, 0, 4'h0, 4'h0);
        add_step(ST_READ,  ADR_ITER,            32'h0000_0000, 0, 4'h0, 4'h0);
        add_step(ST_READ,  ADR_LANE_BASE,       32'h00FF_0000, 0, 4'h0, 4'h0);
        add_step(ST_READ,  ADR_LANE_BASE + 4'd1, 32'h00FF_0000, 0, 4'h0, 4'h0);
        add_step(ST_READ,  ADR_LANE_BASE + 4'd2, 32'h00FF_0000, 0, 4'h0, 4'h0);
        add_step(ST_READ,  ADR_LANE_BASE + 4'd3, 32'h00FF_0000, 0, 4'h0, 4'h0);
        add_step(ST_FLAGS, 4'd0,                32'h0000_0000, 0, 4'h0, 4'h0);
        // Clean training window followed by 12 errors on lane 2 and 3 on lane 0
        add_step(ST_WRITE, ADR_CTRL,            32'h0000_00F1, 0, 4'h0, 4'h0);
        add_step(ST_READ,  ADR_CTRL,            32'h0000_00F1, 0, 4'h0, 4'h0);
        add_step(ST_BURST, 4'd0,                32'h0,        64, 4'hF, 4'h0);
        add_step(ST_READ,  ADR_LANE_BASE,       32'h00FF_0000, 0, 4'h0, 4'h0);
        add_step(ST_READ,  ADR_LANE_BASE + 4'd1, 32'h00FF_0000, 0, 4'h0, 4'h0);
        add_step(ST_READ,  ADR_LANE_BASE + 4'd2, 32'h00FF_0000, 0, 4'h0, 4'h0);
        add_step(ST_READ,  ADR_LANE_BASE + 4'd3, 32'h00FF_0000, 0, 4'h0, 4'h0);
        add_step(ST_BURST, 4'd0,                32'h0,         3, 4'hF, 4'h5);
        add_step(ST_BURST, 4'd0,                32'h0,         9, 4'hF, 4'h4);
        add_step(ST_BURST, 4'd0,                32'h0,        52, 4'hF, 4'h0);
        add_step(ST_READ,  ADR_LANE_BASE,       32'h00FC_0003, 0, 4'h0, 4'h0);
        add_step(ST_READ,  ADR_LANE_BASE + 4'd1, 32'h00FF_0000, 0, 4'h0, 4'h0);
        add_step(ST_READ,  ADR_LANE_BASE + 4'd2, 32'h01F3_000C, 0, 4'h0, 4'h0);
        add_step(ST_READ,  ADR_LANE_BASE + 4'd3, 32'h00FF_0000, 0, 4'h0, 4'h0);
        add_step(ST_READ,  ADR_STATUS,          32'h4000_0401, 0, 4'h0, 4'h0);
        add_step(ST_FLAGS, 4'd0,                32'h0000_0004, 0, 4'h0, 4'h0);
        // Wrong symbols with training off are counted but never scored
        add_step(ST_WRITE, ADR_CTRL,            32'h0000_00F0, 0, 4'h0, 4'h0);
        add_step(ST_BURST, 4'd0,                32'h0,        64, 4'hF, 4'hF);
        add_step(ST_READ,  ADR_LANE_BASE,       32'h00FF_0000, 0, 4'h0, 4'h0);
        add_step(ST_READ,  ADR_LANE_BASE + 4'd1, 32'h00FF_0000, 0, 4'h0, 4'h0);
        add_step(ST_READ,  ADR_LANE_BASE + 4'd2, 32'h00FF_0000, 0, 4'h0, 4'h0);
        add_step(ST_READ,  ADR_LANE_BASE + 4'd3, 32'h00FF_0000, 0, 4'h0, 4'h0);
        add_step(ST_FLAGS, 4'd0,                32'h0000_0000, 0, 4'h0, 4'h0);
        add_step(ST_BURST, 4'd0,                32'h0,         6, 4'hF, 4'hF);
        // Lane 1 gets 5 errors, then is frozen mid-window
        add_step(ST_WRITE, ADR_CTRL,            32'h0000_00F1, 0, 4'h0, 4'h0);
        add_step(ST_BURST, 4'd0,                32'h0,         5, 4'hF, 4'h2);
        add_step(ST_BURST, 4'd0,                32'h0,        53, 4'hF, 4'h0);
        add_step(ST_READ,  ADR_LANE_BASE + 4'd1, 32'h00FA_0005, 0, 4'h0, 4'h0);
        add_step(ST_BURST, 4'd0,                32'h0,         7, 4'hF, 4'h0);
        add_step(ST_WRITE, ADR_CTRL,            32'h0000_00D1, 0, 4'h0, 4'h0);
        add_step(ST_READ,  ADR_STATUS,          32'h4000_0300, 0, 4'h0, 4'h0);
        // Long enough to close a window if lane 1 were not frozen
        add_step(ST_BURST, 4'd0,                32'h0,        60, 4'hF, 4'h2);
        add_step(ST_READ,  ADR_LANE_BASE + 4'd1, 32'h00FA_0005, 0, 4'h0, 4'h0);
        add_step(ST_WRITE, ADR_CTRL,            32'h0000_00F1, 0, 4'h0, 4'h0);
        add_step(ST_BURST, 4'd0,                32'h0,        57, 4'hF, 4'h0);
        add_step(ST_READ,  ADR_LANE_BASE + 4'd1, 32'h00FF_0000, 0, 4'h0, 4'h0);
        add_step(ST_READ,  ADR_LANE_BASE,       32'h00FF_0000, 0, 4'h0, 4'h0);
        // Iteration counter runs with training and holds without
        add_step(ST_ITER_SNAP, ADR_ITER,        32'h0,         0, 4'h0, 4'h0);
        add_step(ST_IDLE,  4'd0,                32'h0,        10, 4'h0, 4'h0);
        add_step(ST_ITER_UP,   ADR_ITER,        32'h0,         0, 4'h0, 4'h0);
        add_step(ST_WRITE, ADR_CTRL,            32'h0000_00F0, 0, 4'h0, 4'h0);
        add_step(ST_IDLE,  4'd0,                32'h0,         3, 4'h0, 4'h0);
        add_step(ST_READ,  ADR_STATUS,          32'h0000_0400, 0, 4'h0, 4'h0);
        add_step(ST_ITER_SNAP, ADR_ITER,        32'h0,         0, 4'h0, 4'h0);
        add_step(ST_IDLE,  4'd0,                32'h0,        20, 4'h0, 4'h0);
        add_step(ST_ITER_HOLD, ADR_ITER,        32'h0,         0, 4'h0, 4'h0);
        // Read-only and unmapped addresses
        add_step(ST_WRITE, ADR_STATUS,          32'hFFFF_FFFF, 0, 4'h0, 4'h0);
        add_step(ST_READ,  ADR_STATUS,          32'h0000_0400, 0, 4'h0, 4'h0);
        add_step(ST_READ,  4'd3,                32'h0000_0000, 0, 4'h0, 4'h0);
        add_step(ST_WRITE, 4'd3,                32'hFFFF_FFFF, 0, 4'h0, 4'h0);
        add_step(ST_READ,  ADR_CTRL,            32'h0000_00F0, 0, 4'h0, 4'h0);
        add_step(ST_READ,  4'd15,               32'h0000_0000, 0, 4'h0, 4'h0);
    endtask

    task automatic wb_access(input logic we, input wb_adr_t adr, input wb_dat_t dat,
                             output wb_dat_t rdata);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 8) begin
                abort_run($sformatf("No acknowledge from the DUT for address %0d", adr));
            end
        end while (!wb_rsp.ack);
        rdata = wb_rsp.dat;
        wb_req = '0;
    endtask

    task automatic send_symbols(input int count, input lane_mask_t valid_mask,
                                input lane_mask_t err_mask);
        for (int n = 0; n < count; n++) begin
            @(negedge clk);
            for (int i = 0; i < NUM_LANES; i++) begin
                rx_valid[i] = valid_mask[i];
                // Pattern follows the lane's own accepted count and is inverted to force an error
                rx_symbols[i] = sym_t'(lane_cnt[i]) ^ (err_mask[i] ? 2'b11 : 2'b00);
                if (valid_mask[i] && lane_en[i]) begin
                    lane_cnt[i]++;
                end
            end
        end
        @(negedge clk);
        rx_valid = '0;
    endtask

    task automatic run_step(input step_t s);
        wb_dat_t rdata;
        case (s.kind)
            ST_WRITE: begin
                wb_access(1'b1, s.adr, s.dat, rdata);
                if (s.adr == ADR_CTRL) begin
                    lane_en = s.dat[CTRL_EN_LSB +: NUM_LANES];
                end
            end
            ST_READ: begin
                wb_access(1'b0, s.adr, '0, rdata);
                check_value($sformatf("rd_data at address %0d", s.adr), rdata, s.dat);
            end
            ST_BURST: send_symbols(int'(s.count), s.valid_mask, s.err_mask);
            ST_IDLE:  repeat (s.count) @(negedge clk);
            ST_FLAGS: begin
                @(negedge clk);
                check_value("lane_error_flag", wb_dat_t'(lane_error_flag), s.dat);
            end
            ST_ITER_SNAP: wb_access(1'b0, ADR_ITER, '0, iter_snap);
            ST_ITER_UP: begin
                wb_access(1'b0, ADR_ITER, '0, rdata);
                check_value("ITER increased", wb_dat_t'(rdata > iter_snap), 32'd1);
                iter_snap = rdata;
            end
            default: begin
                wb_access(1'b0, ADR_ITER, '0, rdata);
                check_value("ITER", rdata, iter_snap);
            end
        endcase
    endtask

    initial begin
        wb_req      = '0;
        rx_symbols  = '0;
        rx_valid    = '0;
        lane_en     = '0;
        iter_snap   = '0;
        num_steps   = 0;
        table_ready = 1'b0;
        foreach (lane_cnt[i]) begin
            lane_cnt[i] = 0;
        end
        build_table();
        table_ready = 1'b1;
        wait (rst_n === 1'b1);
        for (int i = 0; i < num_steps; i++) begin
            run_step(steps[i]);
        end
        $display("test passed");
        $finish;
    end

    // Time budget of twice the table's symbol and idle cycles plus ten cycles per access
    initial begin
        longint limit_cycles;
        limit_cycles = 0;
        wait (table_ready);
        for (int i = 0; i < num_steps; i++) begin
            if (steps[i].kind == ST_BURST || steps[i].kind == ST_IDLE) begin
                limit_cycles += longint'(steps[i].count);
            end else begin
                limit_cycles += 10;
            end
        end
        limit_cycles = 2 * limit_cycles + 16;
        #(limit_cycles * 100);
        abort_run("Watchdog timeout: the run did not finish in time");
    end

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held for 16 full cycles and released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule
